/* bench/bus_panel_assertions.sv */
`include "bus_panel_defs.svh"

module bus_panel_assertions import bus_panel_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic               req_valid,
    input logic               req_ready,
    input logic               resp_valid,
    input logic               resp_ready,
    input logic [`BUS_DW-1:0] resp_rdata,
    input logic               resp_err,
    input bus_state_e         state,
    input logic               bank_wr,
    input logic               hit_q
);

    logic accept;

    assign accept = req_valid && req_ready;

    // accepted on one edge, resp_valid high after the next
    resp_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##2 $rose(resp_valid))
        else $error("resp_valid did not rise one cycle after acceptance");

    // no response without an acceptance just before it
    resp_only_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(resp_valid) |-> $past(accept, 2))
        else $error("resp_valid rose without an acceptance the cycle before");

    resp_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_err))
        else $error("response changed while waiting for resp_ready");

    // ready stays low from acceptance until the response is taken
    ready_low_until_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (accept || state != IDLE) && !(resp_valid && resp_ready) |=> !req_ready)
        else $error("req_ready rose before the response was taken");

    no_write_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        bank_wr |-> hit_q)
        else $error("bank write issued for a decode miss");

endmodule

bind bus_ctrl bus_panel_assertions u_ctrl_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .state      (state),
    .bank_wr    (bank_wr),
    .hit_q      (hit_q)
);

/* bench/bus_panel_tb.sv */
module bus_panel_tb;

    localparam int n_fill  = 24;
    localparam int n_reads = 32;
    localparam int n_dflt  = 8;
    localparam int n_miss  = 16;
    localparam int n_stall = 30;
    localparam int n_txn   = n_fill + n_reads + n_dflt + n_miss + n_stall;
    localparam int n_press = 32;
    localparam int timeout_cycles = n_txn * 20 + n_press * 10 + 100;

    // window nibble per slot with slot 5 at 0xA
    localparam logic [3:0] win_nibble [8] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'hA, 4'h6, 4'h7};
    localparam logic [3:0] miss_nibble [8] = '{4'h5, 4'h8, 4'h9, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
    localparam logic [7:0] page_pat [7] = '{8'h0F, 8'hF0, 8'h0F, 8'hAA, 8'h55, 8'hF0, 8'h0F};

    logic        clk, rst_n, req_valid, req_ready, req_write;
    logic        resp_valid, resp_ready, resp_err, btn_up, btn_down;
    logic [31:0] req_addr, req_wdata, resp_rdata;
    logic [7:0]  led8;
    logic [3:0]  led4;

    logic [31:0] model_mem [24];
    logic [7:0]  model_cnt [8];
    logic [7:0]  model_err;
    logic [32:0] exp_q [$];     // {err, rdata}
    logic [31:0] stim_seed;
    logic [31:0] stall_seed;
    logic        bp_mode;
    int          stall_left;
    int          exp_page;

    bus_panel_top dut (.*);

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg(stim_seed);
        return stim_seed;
    endfunction

    function automatic logic [31:0] slot_addr(input int slot, input int word);
        logic [31:0] r;
        r = next_rand();
        return {win_nibble[slot], r[27:4], 2'(word), r[1:0]};
    endfunction

    // model of the address map, word store and panel counters
    function automatic void expect_resp(input logic wr, input logic [31:0] addr,
                                        input logic [31:0] wdata,
                                        output logic [31:0] rdata, output logic err);
        int  slot;
        logic found;
        found = 1'b0;
        slot  = 0;
        for (int i = 0; i < 8; i++) begin
            if (!found && addr[31:28] == win_nibble[i]) begin
                found = 1'b1;
                slot  = i;
            end
        end
        rdata = '0;
        err   = !found;
        if (!found) begin
            model_err = model_err + 8'd1;
        end else begin
            model_cnt[slot] = model_cnt[slot] + 8'd1;
            if (slot < 6 && wr)
                model_mem[slot * 4 + int'(addr[3:2])] = wdata;
            else if (slot < 6)
                rdata = model_mem[slot * 4 + int'(addr[3:2])];
        end
    endfunction

    function automatic logic [7:0] panel_byte(input int page);
        if (page < 8)
            return ~model_cnt[page];
        else if (page == 8)
            return ~model_err;
        return ~page_pat[page - 9];  // LEDs active low
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // called just after a rising edge and returns the same way after acceptance
    task automatic send(input logic wr, input logic [31:0] addr, input logic [31:0] data);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        @(negedge clk);
        while (!req_ready)
            @(negedge clk);
        @(posedge clk);
        #10;
        req_valid = 1'b0;
    endtask

    task automatic press_button(input logic up);
        if (up)
            btn_up = 1'b1;
        else
            btn_down = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        exp_page = up ? (exp_page + 1) % 16 : (exp_page + 15) % 16;
        check("led4", 32'(led4), 32'(exp_page));
        check("led8", 32'(led8), 32'(panel_byte(exp_page)));
        btn_up   = 1'b0;
        btn_down = 1'b0;
        repeat (4) @(posedge clk);
        #10;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // compare process sampling mid-cycle
    always @(negedge clk) begin
        logic [31:0] exp_data;
        logic        exp_err;
        logic [32:0] head;
        if (rst_n && req_valid && req_ready) begin
            expect_resp(req_write, req_addr, req_wdata, exp_data, exp_err);
            exp_q.push_back({exp_err, exp_data});
        end
        if (rst_n && resp_valid) begin
            check("req_ready", 32'(req_ready), 32'd0);
            if (resp_ready && exp_q.size() == 0) begin
                $display("response handshake with no request outstanding");
                abort_run();
            end else if (resp_ready) begin
                head = exp_q.pop_front();
                check("resp_rdata", resp_rdata, head[31:0]);
                check("resp_err", 32'(resp_err), 32'(head[32]));
            end
        end
    end

    // random resp_ready gaps when back-pressure is on
    initial begin
        stall_seed = lcg(32'h9ba9_8531);
        stall_left = 0;
        forever begin
            @(posedge clk);
            #10;
            if (bp_mode && stall_left > 0) begin
                resp_ready = 1'b0;
                stall_left--;
            end else begin
                resp_ready = 1'b1;
                stall_seed = lcg(stall_seed);
                stall_left = bp_mode ? int'(stall_seed[26:24]) : 0;
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: test did not finish within %0d cycles", timeout_cycles);
        abort_run();
    end

    initial begin
        logic [31:0] r;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        resp_ready = 1'b0;
        btn_up     = 1'b0;
        btn_down   = 1'b0;
        bp_mode    = 1'b0;
        exp_page   = 0;
        stim_seed  = 32'h9ba9_8531;
        model_err  = '0;
        for (int i = 0; i < 24; i++)
            model_mem[i] = '0;
        for (int i = 0; i < 8; i++)
            model_cnt[i] = '0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check("led4", 32'(led4), 32'd0);
        check("req_ready", 32'(req_ready), 32'd1);
        check("resp_valid", 32'(resp_valid), 32'd0);

        for (int i = 0; i < n_fill; i++)
            send(1'b1, slot_addr(i / 4, i % 4), next_rand());
        for (int i = 0; i < n_reads; i++) begin
            r = next_rand();
            send(1'b0, slot_addr(int'(r[15:8]) % 6, int'(r[21:20])), next_rand());
        end
        for (int i = 0; i < n_dflt; i++)
            send(i % 2 == 0, slot_addr(6 + (i / 2) % 2, i % 4), next_rand());
        for (int i = 0; i < n_miss; i++) begin
            r = next_rand();
            send(i % 2 == 0, {miss_nibble[i / 2], r[27:0]}, next_rand());
        end

        bp_mode = 1'b1;
        for (int i = 0; i < n_stall; i++) begin
            r = next_rand();
            send(r[7], r, next_rand());  // any window, hit or miss
        end
        bp_mode = 1'b0;
        while (exp_q.size() != 0 || resp_valid)
            @(posedge clk);
        repeat (3) @(posedge clk);
        #10;

        for (int i = 0; i < n_press / 2; i++)
            press_button(1'b1);
        for (int i = 0; i < n_press / 2; i++)
            press_button(1'b0);  // first one wraps 0 to 15

        $display("No errors");
        $finish;
    end

endmodule

/* bus_panel.f */
+incdir+design
design/bus_panel_pkg.sv
design/addr_decoder.sv
design/reg_bank.sv
design/status_panel.sv
design/bus_ctrl.sv
design/bus_panel_top.sv
bench/bus_panel_assertions.sv
bench/bus_panel_tb.sv

/* design/addr_decoder.sv */
`include "bus_panel_defs.svh"

module addr_decoder import bus_panel_pkg::*; (
    input  bus_addr_u addr,
    output logic      hit,
    output slot_t     slot,
    output logic      backed
);

    // window table, index is the slot number
    localparam logic [3:0] win_base [`BUS_SLOTS] = '{
        `WIN_BASE_0,
        `WIN_BASE_1,
        `WIN_BASE_2,
        `WIN_BASE_3,
        `WIN_BASE_4,
        `WIN_BASE_5,
        `WIN_BASE_6,
        `WIN_BASE_7
    };

    always_comb begin
        hit  = 1'b0;
        slot = '0;  // also the answer on a miss
        for (int i = 0; i < `BUS_SLOTS; i++) begin
            if (!hit && (addr.fld.window == win_base[i])) begin
                hit  = 1'b1;
                slot = slot_t'(i);
            end
        end
    end

    // low slots live in the register bank, the rest are default slaves
    assign backed = hit && (slot < slot_t'(`BACKED_SLOTS));

endmodule

/* design/bus_ctrl.sv */
`include "bus_panel_defs.svh"

module bus_ctrl import bus_panel_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  logic               req_write,
    input  logic [`BUS_DW-1:0] req_addr,
    input  logic [`BUS_DW-1:0] req_wdata,
    output logic               resp_valid,
    input  logic               resp_ready,
    output logic [`BUS_DW-1:0] resp_rdata,
    output logic               resp_err,
    output bus_addr_u          dec_addr,
    input  logic               hit,
    input  slot_t              slot,
    input  logic               backed,
    output logic               bank_wr,
    output logic               bank_rd,
    output slot_t              bank_slot,
    output word_t              bank_word,
    output logic [`BUS_DW-1:0] bank_wdata,
    input  logic [`BUS_DW-1:0] bank_rdata,
    output logic               access_done,
    output slot_t              done_slot,
    output logic               done_err
);

    bus_state_e         state;
    bus_state_e         state_nxt;
    logic               accept;
    logic               write_q;
    logic               hit_q;
    logic               backed_q;
    slot_t              slot_q;
    word_t              word_q;
    logic [`BUS_DW-1:0] wdata_q;

    assign dec_addr  = req_addr;
    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept)
                    state_nxt = ACCESS;
            end
            ACCESS: state_nxt = RESP;  // bank acts on this edge
            RESP: begin
                if (resp_ready)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            write_q     <= 1'b0;
            hit_q       <= 1'b0;
            backed_q    <= 1'b0;
            access_done <= 1'b0;
        end else begin
            state       <= state_nxt;
            access_done <= (state == ACCESS);  // pulse alongside resp_valid rise
            if (accept) begin
                write_q  <= req_write;
                hit_q    <= hit;
                backed_q <= backed;
            end
        end
    end

    // request payload, only meaningful after acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_q  <= slot;
            word_q  <= dec_addr.fld.word;
            wdata_q <= req_wdata;
        end
    end

    // only register backed hits touch the bank
    assign bank_wr    = (state == ACCESS) && backed_q && write_q;
    assign bank_rd    = (state == ACCESS) && backed_q && !write_q;
    assign bank_slot  = slot_q;
    assign bank_word  = word_q;
    assign bank_wdata = wdata_q;

    assign resp_valid = (state == RESP);
    assign resp_rdata = (backed_q && !write_q) ? bank_rdata : '0;  // default slaves read 0
    assign resp_err   = !hit_q;

    assign done_slot = slot_q;
    assign done_err  = !hit_q;

endmodule

/* design/bus_panel_defs.svh */
`ifndef BUS_PANEL_DEFS_SVH
`define BUS_PANEL_DEFS_SVH

// bus geometry
`define BUS_DW          32
`define BUS_SLOTS       8
`define BACKED_SLOTS    6
`define WORDS_PER_SLOT  4

// top address nibble of each 256 MB window
`define WIN_BASE_0      4'h0
`define WIN_BASE_1      4'h1
`define WIN_BASE_2      4'h2
`define WIN_BASE_3      4'h3
`define WIN_BASE_4      4'h4
`define WIN_BASE_5      4'hA    // moved up from 0x5
`define WIN_BASE_6      4'h6
`define WIN_BASE_7      4'h7

// status panel
`define PAGE_COUNT      16
`define LED_WIDTH       8

`define PAGE_PAT_9      8'h0F
`define PAGE_PAT_10     8'hF0
`define PAGE_PAT_11     8'h0F
`define PAGE_PAT_12     8'hAA
`define PAGE_PAT_13     8'h55
`define PAGE_PAT_14     8'hF0
`define PAGE_PAT_15     8'h0F

`endif

/* design/bus_panel_pkg.sv */
`include "bus_panel_defs.svh"

package bus_panel_pkg;

    // field view of a bus address
    typedef struct packed {
        logic [3:0]  window;     // selects the slave window
        logic [23:0] offset_hi;  // don't care
        logic [1:0]  word;       // word inside a backed slot
        logic [1:0]  byte_sel;   // don't care, word access only
    } bus_addr_fields_t;

    // same word read raw or by fields
    typedef union packed {
        logic [`BUS_DW-1:0] raw;
        bus_addr_fields_t   fld;
    } bus_addr_u;

    typedef logic [2:0] slot_t;
    typedef logic [1:0] word_t;
    typedef logic [3:0] page_t;

    // one access in flight at a time
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } bus_state_e;

endpackage

/* design/bus_panel_top.sv */
`include "bus_panel_defs.svh"

module bus_panel_top import bus_panel_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [`BUS_DW-1:0]    req_addr,
    input  logic [`BUS_DW-1:0]    req_wdata,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [`BUS_DW-1:0]    resp_rdata,
    output logic                  resp_err,
    input  logic                  btn_up,
    input  logic                  btn_down,
    output logic [`LED_WIDTH-1:0] led8,
    output logic [3:0]            led4
);

    bus_addr_u          dec_addr;
    logic               hit;
    slot_t              slot;
    logic               backed;
    logic               bank_wr;
    logic               bank_rd;
    slot_t              bank_slot;
    word_t              bank_word;
    logic [`BUS_DW-1:0] bank_wdata;
    logic [`BUS_DW-1:0] bank_rdata;
    logic               access_done;
    slot_t              done_slot;
    logic               done_err;

    bus_ctrl u_bus_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_rdata  (resp_rdata),
        .resp_err    (resp_err),
        .dec_addr    (dec_addr),
        .hit         (hit),
        .slot        (slot),
        .backed      (backed),
        .bank_wr     (bank_wr),
        .bank_rd     (bank_rd),
        .bank_slot   (bank_slot),
        .bank_word   (bank_word),
        .bank_wdata  (bank_wdata),
        .bank_rdata  (bank_rdata),
        .access_done (access_done),
        .done_slot   (done_slot),
        .done_err    (done_err)
    );

    addr_decoder u_addr_decoder (
        .addr   (dec_addr),
        .hit    (hit),
        .slot   (slot),
        .backed (backed)
    );

    reg_bank u_reg_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (bank_wr),
        .rd    (bank_rd),
        .slot  (bank_slot),
        .word  (bank_word),
        .wdata (bank_wdata),
        .rdata (bank_rdata)
    );

    status_panel u_status_panel (
        .clk         (clk),
        .rst_n       (rst_n),
        .access_done (access_done),
        .done_slot   (done_slot),
        .done_err    (done_err),
        .btn_up      (btn_up),
        .btn_down    (btn_down),
        .led8        (led8),
        .led4        (led4)
    );

endmodule

/* design/reg_bank.sv */
`include "bus_panel_defs.svh"

module reg_bank import bus_panel_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr,
    input  logic               rd,
    input  slot_t              slot,
    input  word_t              word,
    input  logic [`BUS_DW-1:0] wdata,
    output logic [`BUS_DW-1:0] rdata
);

    localparam int depth = `BACKED_SLOTS * `WORDS_PER_SLOT;

    logic [`BUS_DW-1:0] mem [depth];
    logic [4:0]         idx;

    // flat word index
    assign idx = 5'(slot) * 5'(`WORDS_PER_SLOT) + 5'(word);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (wr)
                mem[idx] <= wdata;
            if (rd)
                rdata <= mem[idx];  // one edge of read latency
        end
    end

endmodule

/* design/status_panel.sv */
`include "bus_panel_defs.svh"

module status_panel import bus_panel_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  access_done,
    input  slot_t                 done_slot,
    input  logic                  done_err,
    input  logic                  btn_up,
    input  logic                  btn_down,
    output logic [`LED_WIDTH-1:0] led8,
    output page_t                 led4
);

    logic [`LED_WIDTH-1:0] slot_cnt [`BUS_SLOTS];
    logic [`LED_WIDTH-1:0] err_cnt;
    logic [`LED_WIDTH-1:0] page_byte [`PAGE_COUNT];
    logic [2:0]            up_sync;
    logic [2:0]            down_sync;
    logic                  up_rise;
    logic                  down_rise;
    page_t                 page;

    // access statistics, all counters wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BUS_SLOTS; i++) begin
                slot_cnt[i] <= '0;
            end
            err_cnt <= '0;
        end else if (access_done) begin
            if (done_err)
                err_cnt <= err_cnt + 1'b1;
            else
                slot_cnt[done_slot] <= slot_cnt[done_slot] + 1'b1;
        end
    end

    // two sync flops plus one for the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_sync   <= '0;
            down_sync <= '0;
        end else begin
            up_sync   <= {up_sync[1:0], btn_up};
            down_sync <= {down_sync[1:0], btn_down};
        end
    end

    assign up_rise   = up_sync[1] && !up_sync[2];
    assign down_rise = down_sync[1] && !down_sync[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page <= '0;
        end else begin
            case ({up_rise, down_rise})
                2'b10:   page <= page + 1'b1;  // wraps at 16
                2'b01:   page <= page - 1'b1;
                default: page <= page;         // both or neither
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < `BUS_SLOTS; i++) begin
            page_byte[i] = slot_cnt[i];
        end
        page_byte[8]  = err_cnt;
        page_byte[9]  = `PAGE_PAT_9;
        page_byte[10] = `PAGE_PAT_10;
        page_byte[11] = `PAGE_PAT_11;
        page_byte[12] = `PAGE_PAT_12;
        page_byte[13] = `PAGE_PAT_13;
        page_byte[14] = `PAGE_PAT_14;
        page_byte[15] = `PAGE_PAT_15;
    end

    // LEDs are active low
    assign led8 = ~page_byte[page];
    assign led4 = page;

endmodule

/* run.sh */
#!/bin/sh
# build and run the bus panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module bus_panel_tb -f bus_panel.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vbus_panel_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^No errors$"; then
    exit 0
fi
exit 1
